//--- hw/sdram_arb_config.svh
`ifndef SDRAM_ARB_CONFIG_SVH
`define SDRAM_ARB_CONFIG_SVH

// memory port geometry
`define SDRAM_ADDR_W 22
`define SDRAM_DATA_W 128

// scan counters
`define SCAN_W 10

// 640x480 timing, blanking included
`define H_TOTAL 800
`define V_TOTAL 525

// line fetch may only start on the last column
`define LB_FETCH_COL 799

// renderer hands the port back here so the fetch window opens on time
`define LB_YIELD_COL 785

`endif

//--- hw/sdram_arb_pkg.sv
`default_nettype none
`include "sdram_arb_config.svh"

package sdram_arb_pkg;

	typedef logic [`SDRAM_ADDR_W-1:0] mem_addr_t;
	typedef logic [`SDRAM_DATA_W-1:0] mem_data_t;
	typedef logic [`SCAN_W-1:0] scan_pos_t;

	// request toward the memory controller
	typedef struct packed {
		mem_addr_t addr;
		logic [`SDRAM_DATA_W/8-1:0] be;
		logic read;
		logic write;
		mem_data_t wrdata;
	} mem_req_t;

	typedef struct packed {
		mem_addr_t addr;
		logic rd;
		logic wr;
		mem_data_t wrdata;
	} client_req_t;

	typedef struct packed {
		logic cs_n;
		logic sclk;
		logic mosi;
	} spi_pins_t;

	typedef enum logic [2:0] {OWN_NONE, OWN_INIT, OWN_LB, OWN_BG, OWN_PCM} owner_e;

	typedef enum logic [3:0] {BOOTUP, INIT_SDRAM, INIT_DONE, LB_PRE, LB_FETCH, LB_MID,
		LB_DONE, BACKGROUND, PCM, PCM_DONE, HALTED} arb_state_e;

endpackage

`default_nettype wire

//--- hw/scan_counter.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_arb_config.svh"

module scan_counter import sdram_arb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	output scan_pos_t draw_x_o,
	output scan_pos_t draw_y_o,
	output logic new_frame_o
);

	scan_pos_t draw_x;
	scan_pos_t draw_y;
	logic line_end;
	logic frame_end;

	assign line_end = (draw_x == scan_pos_t'(`H_TOTAL - 1));
	assign frame_end = (draw_y == scan_pos_t'(`V_TOTAL - 1));

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			draw_x <= '0;
			draw_y <= '0;
		end
		else
		begin
			if (line_end)
			begin
				draw_x <= '0;
				// rows only move at the end of a line
				if (frame_end)
					draw_y <= '0;
				else
					draw_y <= draw_y + 1'b1;
			end
			else
				draw_x <= draw_x + 1'b1;
		end
	end

	assign draw_x_o = draw_x;
	assign draw_y_o = draw_y;
	// high for the single cycle at the top-left pixel
	assign new_frame_o = (draw_x == '0) && (draw_y == '0);

endmodule

`default_nettype wire

//--- hw/arb_state_ctrl.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_arb_config.svh"

module arb_state_ctrl import sdram_arb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire scan_pos_t draw_x_i,
	input wire logic new_frame_i,
	input wire logic init_done_i,
	input wire logic lb_busy_i,
	input wire logic lb_done_i,
	input wire logic bg_busy_i,
	input wire logic bg_writedone_i,
	input wire logic i2s_done_i,
	output owner_e owner_o,
	output logic init_phase_o,
	output logic bg_wait_low_o,
	output logic init_wait_o
);

	arb_state_e state;
	arb_state_e state_next;
	logic at_fetch_col;
	logic at_yield_col;

	assign at_fetch_col = (draw_x_i == scan_pos_t'(`LB_FETCH_COL));
	assign at_yield_col = (draw_x_i == scan_pos_t'(`LB_YIELD_COL));

	always_ff @(posedge clk)
	begin
		if (reset)
			state <= BOOTUP;
		else
			state <= state_next;
	end

	always_comb
	begin
		state_next = state;
		case (state)
			BOOTUP:
				if (new_frame_i)
					state_next = INIT_SDRAM;
			INIT_SDRAM:
				if (init_done_i)
					state_next = INIT_DONE;
			INIT_DONE:
				if (new_frame_i)
					state_next = LB_PRE;
			// wait for the renderer to finish its access before fetching
			LB_PRE:
				if (at_fetch_col && !bg_busy_i)
					state_next = LB_FETCH;
			LB_FETCH:
				if (lb_done_i)
					state_next = LB_DONE;
				else if (!lb_busy_i)
					state_next = LB_MID;
			LB_MID:
				if (!bg_writedone_i)
					state_next = BACKGROUND;
				else if (at_yield_col)
					state_next = LB_PRE;
			LB_DONE:
				if (!bg_writedone_i)
					state_next = BACKGROUND;
				else
					state_next = PCM;
			BACKGROUND:
				if (lb_done_i)
				begin
					if (bg_writedone_i)
						state_next = PCM;
				end
				else if (at_yield_col)
					state_next = LB_PRE;
			PCM:
				if (i2s_done_i)
					state_next = PCM_DONE;
			PCM_DONE:
				state_next = HALTED;
			HALTED:
				if (new_frame_i)
					state_next = LB_PRE;
			default:
				state_next = BOOTUP;
		endcase
	end

	// owner decode
	always_comb
	begin
		case (state)
			BOOTUP, INIT_SDRAM:
				owner_o = OWN_INIT;
			INIT_DONE, LB_FETCH:
				owner_o = OWN_LB;
			// LB_PRE lets an access in flight complete
			BACKGROUND, LB_PRE:
				owner_o = OWN_BG;
			PCM:
				owner_o = OWN_PCM;
			default:
				owner_o = OWN_NONE;
		endcase
	end

	assign init_phase_o = (state == BOOTUP) || (state == INIT_SDRAM);
	assign bg_wait_low_o = (state == BACKGROUND);
	assign init_wait_o = (state == BOOTUP);

endmodule

`default_nettype wire

//--- hw/arb_port_router.sv
`timescale 1ns/1ns
`default_nettype none

module arb_port_router import sdram_arb_pkg::*;
(
	input wire owner_e owner_i,
	input wire logic init_phase_i,
	input wire logic bg_wait_low_i,
	input wire client_req_t init_req_i,
	input wire client_req_t lb_req_i,
	input wire client_req_t bg_req_i,
	input wire client_req_t pcm_req_i,
	input wire logic mem_ac_i,
	input wire mem_data_t mem_rddata_i,
	output mem_req_t mem_req_o,
	output logic init_ac_o,
	output logic lb_wait_o,
	output logic lb_ac_o,
	output mem_data_t lb_rddata_o,
	output logic bg_wait_o,
	output logic bg_ac_o,
	output mem_data_t bg_rddata_o,
	output logic pcm_wait_o,
	output logic pcm_ac_o,
	output mem_data_t pcm_rddata_o,
	input wire spi_pins_t init_spi_i,
	input wire spi_pins_t usb_spi_i,
	input wire logic spi_miso_i,
	output spi_pins_t spi_o,
	output logic init_miso_o,
	output logic usb_miso_o
);

	// memory side
	always_comb
	begin
		mem_req_o.addr = '0;
		mem_req_o.be = '1;
		mem_req_o.read = 1'b0;
		mem_req_o.write = 1'b0;
		mem_req_o.wrdata = '0;
		case (owner_i)
			// initializer only writes
			OWN_INIT:
			begin
				mem_req_o.addr = init_req_i.addr;
				mem_req_o.write = init_req_i.wr;
				mem_req_o.wrdata = init_req_i.wrdata;
			end
			OWN_LB:
			begin
				mem_req_o.addr = lb_req_i.addr;
				mem_req_o.read = lb_req_i.rd;
			end
			OWN_BG:
			begin
				mem_req_o.addr = bg_req_i.addr;
				mem_req_o.read = bg_req_i.rd;
				mem_req_o.write = bg_req_i.wr;
				mem_req_o.wrdata = bg_req_i.wrdata;
			end
			OWN_PCM:
			begin
				mem_req_o.addr = pcm_req_i.addr;
				mem_req_o.read = pcm_req_i.rd;
			end
			default:
			begin
				mem_req_o.addr = '0;
			end
		endcase
	end

	// acknowledge goes to the owner only
	assign init_ac_o = (owner_i == OWN_INIT) && mem_ac_i;
	assign lb_ac_o = (owner_i == OWN_LB) && mem_ac_i;
	assign bg_ac_o = (owner_i == OWN_BG) && mem_ac_i;
	assign pcm_ac_o = (owner_i == OWN_PCM) && mem_ac_i;

	assign lb_wait_o = (owner_i != OWN_LB);
	// renderer in LB_PRE still owns the port but is told to wait
	assign bg_wait_o = !bg_wait_low_i;
	assign pcm_wait_o = (owner_i != OWN_PCM);

	assign lb_rddata_o = (owner_i == OWN_LB) ? mem_rddata_i : '0;
	assign bg_rddata_o = (owner_i == OWN_BG) ? mem_rddata_i : '0;
	assign pcm_rddata_o = mem_rddata_i;

	// SPI bus to the SD card during boot, USB afterwards
	always_comb
	begin
		if (init_phase_i)
		begin
			spi_o.cs_n = 1'b0;
			spi_o.sclk = init_spi_i.sclk;
			spi_o.mosi = init_spi_i.mosi;
			init_miso_o = spi_miso_i;
			usb_miso_o = 1'b0;
		end
		else
		begin
			spi_o = usb_spi_i;
			init_miso_o = 1'b0;
			usb_miso_o = spi_miso_i;
		end
	end

endmodule

`default_nettype wire

//--- hw/sdram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module sdram_arbiter import sdram_arb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	output scan_pos_t draw_x_o,
	output scan_pos_t draw_y_o,
	output logic new_frame_o,
	input wire client_req_t init_req_i,
	input wire logic init_done_i,
	output logic init_ac_o,
	output logic init_wait_o,
	input wire spi_pins_t init_spi_i,
	output logic init_miso_o,
	input wire spi_pins_t usb_spi_i,
	output logic usb_miso_o,
	input wire client_req_t lb_req_i,
	input wire logic lb_busy_i,
	input wire logic lb_done_i,
	output logic lb_wait_o,
	output logic lb_ac_o,
	output mem_data_t lb_rddata_o,
	input wire client_req_t bg_req_i,
	input wire logic bg_busy_i,
	input wire logic bg_writedone_i,
	output logic bg_wait_o,
	output logic bg_ac_o,
	output mem_data_t bg_rddata_o,
	input wire client_req_t pcm_req_i,
	input wire logic i2s_done_i,
	output logic pcm_wait_o,
	output logic pcm_ac_o,
	output mem_data_t pcm_rddata_o,
	output mem_req_t mem_req_o,
	input wire logic mem_ac_i,
	input wire mem_data_t mem_rddata_i,
	input wire logic spi_miso_i,
	output spi_pins_t spi_o,
	output logic sd_cs_o
);

	owner_e owner;
	logic init_phase;
	logic bg_wait_low;

	scan_counter u_scan (
		.clk(clk),
		.reset(reset),
		.draw_x_o(draw_x_o),
		.draw_y_o(draw_y_o),
		.new_frame_o(new_frame_o)
	);

	arb_state_ctrl u_ctrl (
		.clk(clk),
		.reset(reset),
		.draw_x_i(draw_x_o),
		.new_frame_i(new_frame_o),
		.init_done_i(init_done_i),
		.lb_busy_i(lb_busy_i),
		.lb_done_i(lb_done_i),
		.bg_busy_i(bg_busy_i),
		.bg_writedone_i(bg_writedone_i),
		.i2s_done_i(i2s_done_i),
		.owner_o(owner),
		.init_phase_o(init_phase),
		.bg_wait_low_o(bg_wait_low),
		.init_wait_o(init_wait_o)
	);

	arb_port_router u_router (
		.owner_i(owner),
		.init_phase_i(init_phase),
		.bg_wait_low_i(bg_wait_low),
		.init_req_i(init_req_i),
		.lb_req_i(lb_req_i),
		.bg_req_i(bg_req_i),
		.pcm_req_i(pcm_req_i),
		.mem_ac_i(mem_ac_i),
		.mem_rddata_i(mem_rddata_i),
		.mem_req_o(mem_req_o),
		.init_ac_o(init_ac_o),
		.lb_wait_o(lb_wait_o),
		.lb_ac_o(lb_ac_o),
		.lb_rddata_o(lb_rddata_o),
		.bg_wait_o(bg_wait_o),
		.bg_ac_o(bg_ac_o),
		.bg_rddata_o(bg_rddata_o),
		.pcm_wait_o(pcm_wait_o),
		.pcm_ac_o(pcm_ac_o),
		.pcm_rddata_o(pcm_rddata_o),
		.init_spi_i(init_spi_i),
		.usb_spi_i(usb_spi_i),
		.spi_miso_i(spi_miso_i),
		.spi_o(spi_o),
		.init_miso_o(init_miso_o),
		.usb_miso_o(usb_miso_o)
	);

	// SD chip select always tracks the initializer
	assign sd_cs_o = init_spi_i.cs_n;

endmodule

`default_nettype wire

//--- test/arb_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "sdram_arb_config.svh"

module arb_checker import sdram_arb_pkg::*;
(
	input wire logic clk,
	input wire logic reset,
	input wire scan_pos_t draw_x_i,
	input wire scan_pos_t draw_y_i,
	input wire logic new_frame_i,
	input wire logic init_done_i,
	input wire logic lb_busy_i,
	input wire logic lb_done_i,
	input wire logic bg_busy_i,
	input wire logic bg_writedone_i,
	input wire logic i2s_done_i,
	input wire client_req_t init_req_i,
	input wire client_req_t lb_req_i,
	input wire client_req_t bg_req_i,
	input wire client_req_t pcm_req_i,
	input wire logic mem_ac_i,
	input wire mem_data_t mem_rddata_i,
	input wire mem_req_t mem_req_i,
	input wire logic init_ac_i,
	input wire logic init_wait_i,
	input wire logic lb_wait_i,
	input wire logic lb_ac_i,
	input wire mem_data_t lb_rddata_i,
	input wire logic bg_wait_i,
	input wire logic bg_ac_i,
	input wire mem_data_t bg_rddata_i,
	input wire logic pcm_wait_i,
	input wire logic pcm_ac_i,
	input wire mem_data_t pcm_rddata_i,
	input wire spi_pins_t init_spi_i,
	input wire spi_pins_t usb_spi_i,
	input wire logic spi_miso_i,
	input wire spi_pins_t spi_i,
	input wire logic sd_cs_i,
	input wire logic init_miso_i,
	input wire logic usb_miso_i,
	output owner_e owner_o,
	output int errors_o
);

	arb_state_e m_state;
	int m_col;
	int m_row;
	logic m_frame;
	int errors = 0;

	function automatic owner_e owner_for(input arb_state_e s);
		case (s)
			BOOTUP, INIT_SDRAM: return OWN_INIT;
			INIT_DONE, LB_FETCH: return OWN_LB;
			BACKGROUND, LB_PRE: return OWN_BG;
			PCM: return OWN_PCM;
			default: return OWN_NONE;
		endcase
	endfunction

	task automatic report(input string what);
		errors++;
		$display("MISMATCH %0t: %s", $time, what);
	endtask

	// reference scan position
	always @(posedge clk)
	begin
		if (reset)
		begin
			m_col <= 0;
			m_row <= 0;
		end
		else
		begin
			m_col <= (m_col + 1) % `H_TOTAL;
			if (m_col == `H_TOTAL - 1)
				m_row <= (m_row + 1) % `V_TOTAL;
		end
	end

	assign m_frame = (m_col == 0) && (m_row == 0);

	// reference ownership sequence
	always @(posedge clk)
	begin
		if (reset)
			m_state <= BOOTUP;
		else
			case (m_state)
				BOOTUP: if (m_frame) m_state <= INIT_SDRAM;
				INIT_SDRAM: if (init_done_i) m_state <= INIT_DONE;
				INIT_DONE: if (m_frame) m_state <= LB_PRE;
				LB_PRE:
					if (m_col == `LB_FETCH_COL && !bg_busy_i)
						m_state <= LB_FETCH;
				LB_FETCH:
					if (lb_done_i) m_state <= LB_DONE;
					else if (!lb_busy_i) m_state <= LB_MID;
				LB_MID:
					if (!bg_writedone_i) m_state <= BACKGROUND;
					else if (m_col == `LB_YIELD_COL) m_state <= LB_PRE;
				LB_DONE: m_state <= bg_writedone_i ? PCM : BACKGROUND;
				BACKGROUND:
					if (lb_done_i && bg_writedone_i) m_state <= PCM;
					else if (!lb_done_i && m_col == `LB_YIELD_COL)
						m_state <= LB_PRE;
				PCM: if (i2s_done_i) m_state <= PCM_DONE;
				PCM_DONE: m_state <= HALTED;
				HALTED: if (m_frame) m_state <= LB_PRE;
				default: m_state <= BOOTUP;
			endcase
	end

	assign owner_o = owner_for(m_state);
	assign errors_o = errors;

	// outputs are settled at the falling edge
	always @(negedge clk)
	begin
		owner_e own;
		mem_req_t exp_req;
		spi_pins_t exp_spi;
		mem_data_t zero;
		own = owner_for(m_state);
		zero = '0;
		exp_req = '0;
		exp_req.be = '1;
		case (own)
			OWN_INIT:
			begin
				exp_req.addr = init_req_i.addr;
				exp_req.write = init_req_i.wr;
				exp_req.wrdata = init_req_i.wrdata;
			end
			OWN_LB:
			begin
				exp_req.addr = lb_req_i.addr;
				exp_req.read = lb_req_i.rd;
			end
			OWN_BG:
			begin
				exp_req.addr = bg_req_i.addr;
				exp_req.read = bg_req_i.rd;
				exp_req.write = bg_req_i.wr;
				exp_req.wrdata = bg_req_i.wrdata;
			end
			OWN_PCM:
			begin
				exp_req.addr = pcm_req_i.addr;
				exp_req.read = pcm_req_i.rd;
			end
			default:
				exp_req.be = '1;
		endcase
		exp_spi = usb_spi_i;
		if (own == OWN_INIT)
		begin
			exp_spi.cs_n = 1'b0;
			exp_spi.sclk = init_spi_i.sclk;
			exp_spi.mosi = init_spi_i.mosi;
		end
		if (!reset)
		begin
			if (draw_x_i !== scan_pos_t'(m_col)) report("scan column");
			if (draw_y_i !== scan_pos_t'(m_row)) report("scan row");
			if (new_frame_i !== m_frame) report("frame start");
			if (mem_req_i !== exp_req) report($sformatf("memory request, owner %s", own.name()));
			if (init_ac_i !== (own == OWN_INIT && mem_ac_i)) report("init acknowledge");
			if (lb_ac_i !== (own == OWN_LB && mem_ac_i)) report("line buffer acknowledge");
			if (bg_ac_i !== (own == OWN_BG && mem_ac_i)) report("renderer acknowledge");
			if (pcm_ac_i !== (own == OWN_PCM && mem_ac_i)) report("pcm acknowledge");
			if (init_wait_i !== (m_state == BOOTUP)) report("init wait");
			if (lb_wait_i !== (own != OWN_LB)) report("line buffer wait");
			if (bg_wait_i !== (m_state != BACKGROUND)) report("renderer wait");
			if (pcm_wait_i !== (own != OWN_PCM)) report("pcm wait");
			if (lb_rddata_i !== (own == OWN_LB ? mem_rddata_i : zero)) report("line buffer data");
			if (bg_rddata_i !== (own == OWN_BG ? mem_rddata_i : zero)) report("renderer data");
			if (pcm_rddata_i !== mem_rddata_i) report("pcm data");
			if (spi_i !== exp_spi) report("spi pins");
			if (sd_cs_i !== init_spi_i.cs_n) report("sd chip select");
			if (init_miso_i !== (own == OWN_INIT && spi_miso_i)) report("init miso");
			if (usb_miso_i !== (own != OWN_INIT && spi_miso_i)) report("usb miso");
		end
	end

endmodule

`default_nettype wire

//--- test/tb_sdram_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module tb_sdram_arbiter import sdram_arb_pkg::*;
();

	localparam int TIMEOUT = 500000;

	logic clk;
	logic reset;
	client_req_t init_req, lb_req, bg_req, pcm_req;
	logic init_done, lb_busy, lb_done, bg_busy, bg_writedone, i2s_done;
	spi_pins_t init_spi, usb_spi, spi;
	logic spi_miso, mem_ac;
	mem_data_t mem_rddata, lb_rddata, bg_rddata, pcm_rddata;
	mem_req_t mem_req;
	scan_pos_t draw_x, draw_y;
	logic new_frame, init_ac, init_wait, init_miso, usb_miso, sd_cs;
	logic lb_wait, lb_ac, bg_wait, bg_ac, pcm_wait, pcm_ac;
	owner_e model_owner;
	int chk_errors;
	int trace_errors = 0;
	int run_errors = 0;
	logic [15:0] lfsr;

	sdram_arbiter DUT (
		.clk(clk), .reset(reset),
		.draw_x_o(draw_x), .draw_y_o(draw_y), .new_frame_o(new_frame),
		.init_req_i(init_req), .init_done_i(init_done), .init_ac_o(init_ac),
		.init_wait_o(init_wait), .init_spi_i(init_spi), .init_miso_o(init_miso),
		.usb_spi_i(usb_spi), .usb_miso_o(usb_miso),
		.lb_req_i(lb_req), .lb_busy_i(lb_busy), .lb_done_i(lb_done),
		.lb_wait_o(lb_wait), .lb_ac_o(lb_ac), .lb_rddata_o(lb_rddata),
		.bg_req_i(bg_req), .bg_busy_i(bg_busy), .bg_writedone_i(bg_writedone),
		.bg_wait_o(bg_wait), .bg_ac_o(bg_ac), .bg_rddata_o(bg_rddata),
		.pcm_req_i(pcm_req), .i2s_done_i(i2s_done), .pcm_wait_o(pcm_wait),
		.pcm_ac_o(pcm_ac), .pcm_rddata_o(pcm_rddata),
		.mem_req_o(mem_req), .mem_ac_i(mem_ac), .mem_rddata_i(mem_rddata),
		.spi_miso_i(spi_miso), .spi_o(spi), .sd_cs_o(sd_cs)
	);

	arb_checker u_checker (
		.clk(clk), .reset(reset), .draw_x_i(draw_x), .draw_y_i(draw_y),
		.new_frame_i(new_frame),
		.init_done_i(init_done), .lb_busy_i(lb_busy), .lb_done_i(lb_done),
		.bg_busy_i(bg_busy), .bg_writedone_i(bg_writedone), .i2s_done_i(i2s_done),
		.init_req_i(init_req), .lb_req_i(lb_req), .bg_req_i(bg_req), .pcm_req_i(pcm_req),
		.mem_ac_i(mem_ac), .mem_rddata_i(mem_rddata), .mem_req_i(mem_req),
		.init_ac_i(init_ac), .init_wait_i(init_wait), .lb_wait_i(lb_wait), .lb_ac_i(lb_ac),
		.lb_rddata_i(lb_rddata), .bg_wait_i(bg_wait), .bg_ac_i(bg_ac),
		.bg_rddata_i(bg_rddata), .pcm_wait_i(pcm_wait), .pcm_ac_i(pcm_ac),
		.pcm_rddata_i(pcm_rddata), .init_spi_i(init_spi), .usb_spi_i(usb_spi),
		.spi_miso_i(spi_miso), .spi_i(spi), .sd_cs_i(sd_cs), .init_miso_i(init_miso),
		.usb_miso_i(usb_miso), .owner_o(model_owner), .errors_o(chk_errors)
	);

	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// client requests, SPI pins and memory model
	always @(posedge clk)
	begin
		logic [127:0] word;
		word = '0;
		for (int i = 0; i < 128; i++)
		begin
			lfsr = lfsr_next(lfsr);
			word = {word[126:0], lfsr[0]};
		end
		if (reset)
			mem_ac <= 1'b0;
		else
			mem_ac <= (mem_req.read || mem_req.write) && !mem_ac;
		if (mem_req.read)
			mem_rddata <= word;
		init_req <= '{addr: word[21:0], rd: 1'b0, wr: 1'b1, wrdata: word};
		lb_req <= '{addr: word[43:22], rd: 1'b1, wr: 1'b0, wrdata: '0};
		bg_req <= '{addr: word[65:44], rd: word[0], wr: !word[0] && word[1], wrdata: ~word};
		pcm_req <= '{addr: word[87:66], rd: word[2], wr: 1'b0, wrdata: '0};
		init_spi <= word[5:3];
		usb_spi <= word[8:6];
		spi_miso <= word[9];
	end

	task automatic wait_event(input int kind, input int arg, output bit timed_out);
		int n;
		bit hit;
		n = 0;
		hit = 0;
		timed_out = 1'b0;
		while (!hit && !timed_out)
		begin
			@(negedge clk);
			case (kind)
				0: hit = new_frame;
				1: hit = (draw_x == scan_pos_t'(arg));
				default: hit = (model_owner == owner_e'(arg));
			endcase
			n++;
			if (!hit && n > TIMEOUT)
			begin
				$display("timeout waiting for event kind %0d arg %0d", kind, arg);
				timed_out = 1'b1;
			end
		end
	endtask

	initial
	begin
		int fd, cnt, kind, arg, a, b, c, d, e, f, exp_own;
		bit timed_out;
		string line;
		lfsr = 16'd78;
		reset = 1'b1;
		{init_done, lb_busy, lb_done, bg_busy, bg_writedone, i2s_done} = '0;
		{init_req, lb_req, bg_req, pcm_req} = '0;
		{init_spi, usb_spi, spi_miso, mem_ac} = '0;
		mem_rddata = '0;
		timed_out = 1'b0;
		fd = $fopen("test/arb_trace.txt", "r");
		if (fd == 0)
		begin
			$display("could not open the trace file");
			run_errors++;
		end
		else
		begin
			repeat (2) @(posedge clk);
			reset <= 1'b0;
			while (!timed_out && !$feof(fd))
			begin
				line = "";
				cnt = $fgets(line, fd);
				if (line.len() == 0 || line.getc(0) == "#")
					continue;
				cnt = $sscanf(line, "%d %d %d %d %d %d %d %d %d",
					kind, arg, a, b, c, d, e, f, exp_own);
				if (cnt != 9)
					continue;
				wait_event(kind, arg, timed_out);
				if (timed_out)
					run_errors++;
				else
				begin
					if (model_owner != owner_e'(exp_own))
					begin
						trace_errors++;
						$display("MISMATCH %0t: owner %s, trace expects %0d", $time,
							model_owner.name(), exp_own);
					end
					@(posedge clk);
					init_done <= a[0];
					lb_busy <= b[0];
					lb_done <= c[0];
					bg_busy <= d[0];
					bg_writedone <= e[0];
					i2s_done <= f[0];
				end
			end
			$fclose(fd);
			repeat (4) @(negedge clk);
		end
		$display("errors: checker %0d, trace %0d, run %0d",
			chk_errors, trace_errors, run_errors);
		if (chk_errors == 0 && trace_errors == 0 && run_errors == 0)
			$display("TB PASSED");
		else
			$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/arb_trace.txt
# kind (0 frame start, 1 column, 2 owner) arg, then levels to set:
# init_done lb_busy lb_done bg_busy bg_writedone i2s_done, expected owner when the event hits
2 1   0 0 0 0 0 0 1
1 100 1 0 0 0 0 0 1
2 2   0 0 0 0 0 0 2
0 0   0 1 0 1 0 0 2
2 3   0 1 0 0 0 0 3
2 2   0 0 0 0 0 0 2
2 3   0 0 0 0 0 0 3
1 786 0 1 0 0 0 0 3
2 2   0 1 1 0 1 0 2
2 4   0 1 1 0 1 0 4
1 50  0 1 1 0 1 1 4
2 0   0 0 0 0 0 0 0
0 0   0 0 0 0 0 0 0
2 3   0 0 0 0 0 0 3
2 2   0 0 0 0 0 0 2
2 3   0 0 0 0 0 0 3
1 700 0 0 0 0 0 0 3

//--- sdram_arbiter.f
+incdir+hw
hw/sdram_arb_pkg.sv
hw/scan_counter.sv
hw/arb_state_ctrl.sv
hw/arb_port_router.sv
hw/sdram_arbiter.sv
test/arb_checker.sv
test/tb_sdram_arbiter.sv

//--- run_sim.sh
#!/bin/sh
# build and run from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sdram_arbiter.f --top-module tb_sdram_arbiter \
	-o sim_tb > build.log 2>&1 && \
	./obj_dir/sim_tb > sim.log 2>&1 || { echo "build or run error"; exit 1; }
grep -q "TB FAILED" sim.log && { echo "simulation failed"; exit 1; } || \
	{ echo "simulation passed"; exit 0; }
